// ==== axi_mem_cases.txt ====
# op id addr len base strb. W writes, R reads, P writes together with the R line below it.
# id, addr, base and strb are hex, len is the AXI len (beats minus one). Read base/strb unused.
W 1 00000000 31 0123456789ab0000 ff
R 2 00000000 31 0 00
W 3 00000040 3 a5a5a5a500000000 0f
W 4 00000044 1 5a5a5a5a11111111 f0
R 5 00000040 7 0 00
W 6 000003f0 3 c0c0c0c0c0c0c000 ff
R 7 000003f8 2 0 00
W 8 00000400 0 77665544332211ff 3c
W 9 12345408 1 ffeeddccbbaa9900 81
R a 00000000 3 0 00
P b 00000100 7 2222222222222200 ff
R c 00000080 7 0 00
R d 00000100 7 0 00
P e 00000000 15 3333333333333300 55
R f 000000c0 3 0 00
R 0 00000000 15 0 00

// ==== axi_mem_pkg.sv ====
// Serves full-width INCR bursts only and always answers OKAY. ID_W and DATA_W must match the master.
`default_nettype none

package axi_mem_pkg;

  // Bus widths shared by the converter, the bank array and the test environment.
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 64;
  localparam int unsigned ID_W   = 4;
  localparam int unsigned STRB_W = DATA_W / 8;

  // Only incrementing bursts are served.
  localparam logic [1:0] BURST_INCR = 2'b01;
  // Size code of a full 8-byte beat.
  // It is also the number of byte offset bits in a beat address.
  localparam int unsigned SIZE_FULL = 3;
  // The converter never reports an error.
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // Write address channel.
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [1:0]        burst;
  } axi_aw_t;

  // Read address channel carries the same fields as the write address channel.
  typedef axi_aw_t axi_ar_t;

  // Write data channel.
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } axi_w_t;

  // Write response channel.
  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
  } axi_b_t;

  // Read data channel.
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
    logic              last;
  } axi_r_t;

  // Everything the master drives.
  typedef struct packed {
    axi_aw_t aw;
    logic    aw_valid;
    axi_w_t  w;
    logic    w_valid;
    logic    b_ready;
    axi_ar_t ar;
    logic    ar_valid;
    logic    r_ready;
  } axi_req_t;

  // Everything the slave drives.
  typedef struct packed {
    logic   aw_ready;
    logic   w_ready;
    logic   ar_ready;
    logic   b_valid;
    axi_b_t b;
    logic   r_valid;
    axi_r_t r;
  } axi_resp_t;

  // Bookkeeping for one issued beat.
  // The joiner uses it to turn bank answers into an R beat or a B response.
  typedef struct packed {
    logic            we;
    logic [ID_W-1:0] id;
    logic            last;
  } beat_meta_t;

endpackage

`default_nettype wire

// ==== axi_mem_subsys.f ====
axi_mem_pkg.sv
mem_bank_split.sv
mem_resp_join.sv
sram_banks.sv
axi_to_mem.sv
axi_mem_subsys.sv
tb_axi_mem_subsys.sv

// ==== axi_mem_subsys.sv ====
// AXI memory of 2**AddrWidth bytes. Addresses wrap at the top and bank stalls come from outside.
`timescale 1ns/1ps
`default_nettype none

module axi_mem_subsys #(
  parameter int unsigned AddrWidth = 10,
  parameter int unsigned NumBanks  = 2,
  parameter int unsigned BufDepth  = 2
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  axi_mem_pkg::axi_req_t  axi_req_i,
  output axi_mem_pkg::axi_resp_t axi_resp_o,
  input  logic [NumBanks-1:0]    bank_stall_i,
  output logic                   busy_o
);
  import axi_mem_pkg::*;

  localparam int unsigned BankW = DATA_W / NumBanks;

  // Memory stream between the converter and the banks.
  logic [NumBanks-1:0]                mem_req;
  logic [NumBanks-1:0]                mem_gnt;
  logic [NumBanks-1:0][AddrWidth-1:0] mem_addr;
  logic [NumBanks-1:0][BankW-1:0]     mem_wdata;
  logic [NumBanks-1:0][BankW/8-1:0]   mem_strb;
  logic [NumBanks-1:0]                mem_we;
  logic [NumBanks-1:0]                mem_rvalid;
  logic [NumBanks-1:0][BankW-1:0]     mem_rdata;

  axi_to_mem #(
    .AddrWidth ( AddrWidth ),
    .NumBanks  ( NumBanks  ),
    .BufDepth  ( BufDepth  )
  ) i_axi_to_mem (
    .clk_i        ( clk_i      ),
    .arst_n_i     ( arst_n_i   ),
    .busy_o       ( busy_o     ),
    .axi_req_i    ( axi_req_i  ),
    .axi_resp_o   ( axi_resp_o ),
    .mem_req_o    ( mem_req    ),
    .mem_gnt_i    ( mem_gnt    ),
    .mem_addr_o   ( mem_addr   ),
    .mem_wdata_o  ( mem_wdata  ),
    .mem_strb_o   ( mem_strb   ),
    .mem_we_o     ( mem_we     ),
    .mem_rvalid_i ( mem_rvalid ),
    .mem_rdata_i  ( mem_rdata  )
  );

  sram_banks #(
    .AddrWidth ( AddrWidth ),
    .NumBanks  ( NumBanks  )
  ) i_sram_banks (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .bank_stall_i ( bank_stall_i ),
    .mem_req_i    ( mem_req      ),
    .mem_gnt_o    ( mem_gnt      ),
    .mem_addr_i   ( mem_addr     ),
    .mem_wdata_i  ( mem_wdata    ),
    .mem_strb_i   ( mem_strb     ),
    .mem_we_i     ( mem_we       ),
    .mem_rvalid_o ( mem_rvalid   ),
    .mem_rdata_o  ( mem_rdata    )
  );

endmodule

`default_nettype wire

// ==== axi_to_mem.sv ====
// One read and one write burst are active at a time. Bursts must be INCR and full width.
`timescale 1ns/1ps
`default_nettype none

module axi_to_mem #(
  parameter int unsigned AddrWidth = 10,
  parameter int unsigned NumBanks  = 2,
  parameter int unsigned BufDepth  = 2
) (
  input  logic                                                    clk_i,
  input  logic                                                    arst_n_i,
  output logic                                                    busy_o,
  input  axi_mem_pkg::axi_req_t                                   axi_req_i,
  output axi_mem_pkg::axi_resp_t                                  axi_resp_o,
  output logic [NumBanks-1:0]                                     mem_req_o,
  input  logic [NumBanks-1:0]                                     mem_gnt_i,
  output logic [NumBanks-1:0][AddrWidth-1:0]                      mem_addr_o,
  output logic [NumBanks-1:0][axi_mem_pkg::DATA_W/NumBanks-1:0]   mem_wdata_o,
  output logic [NumBanks-1:0][axi_mem_pkg::DATA_W/NumBanks/8-1:0] mem_strb_o,
  output logic [NumBanks-1:0]                                     mem_we_o,
  input  logic [NumBanks-1:0]                                     mem_rvalid_i,
  input  logic [NumBanks-1:0][axi_mem_pkg::DATA_W/NumBanks-1:0]   mem_rdata_i
);
  import axi_mem_pkg::*;

  // Active burst state for each direction.
  logic                 wr_active_q;
  logic                 rd_active_q;
  logic [ID_W-1:0]      wr_id_q;
  logic [ID_W-1:0]      rd_id_q;
  logic [AddrWidth-1:0] wr_addr_q;
  logic [AddrWidth-1:0] rd_addr_q;
  logic [7:0]           wr_len_q;
  logic [7:0]           rd_len_q;
  logic [7:0]           wr_cnt_q;
  logic [7:0]           rd_cnt_q;
  // Arbitration state.
  logic                 last_wr_q;
  logic                 hold_q;
  logic                 hold_wr_q;

  logic       aw_fire;
  logic       ar_fire;
  logic       w_fire;
  logic       wr_elig;
  logic       rd_elig;
  logic       wr_last;
  logic       rd_last;
  logic       pick_wr;
  logic       credit_ok;
  logic       beat_valid;
  logic       beat_ready;
  logic       beat_fire;
  logic       join_idle;
  logic       meta_push;
  beat_meta_t beat_meta;
  beat_meta_t meta_join;

  // An address is taken only while no burst of that kind is active.
  assign axi_resp_o.aw_ready = axi_req_i.aw_valid && !wr_active_q;
  assign axi_resp_o.ar_ready = axi_req_i.ar_valid && !rd_active_q;
  assign aw_fire = axi_resp_o.aw_ready;
  assign ar_fire = axi_resp_o.ar_ready;

  assign wr_elig = wr_active_q && axi_req_i.w_valid;
  assign rd_elig = rd_active_q;
  assign wr_last = (wr_cnt_q == wr_len_q);
  assign rd_last = (rd_cnt_q == rd_len_q);

  // A stalled beat keeps its direction so the bank requests stay stable.
  // Otherwise the direction not served last time wins when both are ready.
  assign pick_wr    = hold_q ? hold_wr_q : (wr_elig && (!rd_elig || !last_wr_q));
  assign beat_valid = credit_ok && (pick_wr ? wr_elig : rd_elig);
  assign beat_fire  = beat_valid && beat_ready;

  // The W beat is consumed together with the write beat that carries it.
  assign axi_resp_o.w_ready = beat_fire && pick_wr;
  assign w_fire = axi_req_i.w_valid && axi_resp_o.w_ready;

  assign beat_meta.we   = pick_wr;
  assign beat_meta.id   = pick_wr ? wr_id_q : rd_id_q;
  assign beat_meta.last = pick_wr ? wr_last : rd_last;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_active_q <= 1'b0;
      rd_active_q <= 1'b0;
      last_wr_q   <= 1'b0;
      hold_q      <= 1'b0;
      hold_wr_q   <= 1'b0;
    end else begin
      if (aw_fire) begin
        wr_active_q <= 1'b1;
      end else if (beat_fire && pick_wr && wr_last) begin
        wr_active_q <= 1'b0;
      end
      if (ar_fire) begin
        rd_active_q <= 1'b1;
      end else if (beat_fire && !pick_wr && rd_last) begin
        rd_active_q <= 1'b0;
      end
      if (beat_fire) begin
        last_wr_q <= pick_wr;
      end
      hold_q    <= beat_valid && !beat_ready;
      hold_wr_q <= pick_wr;
    end
  end

  // Beat addresses start aligned to a full beat and wrap at the end of memory.
  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      wr_id_q   <= axi_req_i.aw.id;
      wr_addr_q <= {axi_req_i.aw.addr[AddrWidth-1:SIZE_FULL], {SIZE_FULL{1'b0}}};
      wr_len_q  <= axi_req_i.aw.len;
      wr_cnt_q  <= '0;
    end else if (beat_fire && pick_wr) begin
      wr_addr_q <= wr_addr_q + AddrWidth'(STRB_W);
      wr_cnt_q  <= wr_cnt_q + 8'd1;
    end
    if (ar_fire) begin
      rd_id_q   <= axi_req_i.ar.id;
      rd_addr_q <= {axi_req_i.ar.addr[AddrWidth-1:SIZE_FULL], {SIZE_FULL{1'b0}}};
      rd_len_q  <= axi_req_i.ar.len;
      rd_cnt_q  <= '0;
    end else if (beat_fire && !pick_wr) begin
      rd_addr_q <= rd_addr_q + AddrWidth'(STRB_W);
      rd_cnt_q  <= rd_cnt_q + 8'd1;
    end
  end

  // Busy covers accepted bursts, beats still being issued and unanswered beats.
  assign busy_o = aw_fire || ar_fire || wr_active_q || rd_active_q || !join_idle;

  mem_bank_split #(
    .AddrWidth ( AddrWidth ),
    .NumBanks  ( NumBanks  )
  ) i_mem_bank_split (
    .clk_i        ( clk_i                                 ),
    .arst_n_i     ( arst_n_i                              ),
    .beat_valid_i ( beat_valid                            ),
    .beat_ready_o ( beat_ready                            ),
    .beat_addr_i  ( pick_wr ? wr_addr_q : rd_addr_q       ),
    .beat_wdata_i ( axi_req_i.w.data                      ),
    .beat_strb_i  ( pick_wr ? axi_req_i.w.strb : '0       ),
    .beat_meta_i  ( beat_meta                             ),
    .meta_push_o  ( meta_push                             ),
    .meta_o       ( meta_join                             ),
    .mem_req_o    ( mem_req_o                             ),
    .mem_gnt_i    ( mem_gnt_i                             ),
    .mem_addr_o   ( mem_addr_o                            ),
    .mem_wdata_o  ( mem_wdata_o                           ),
    .mem_strb_o   ( mem_strb_o                            ),
    .mem_we_o     ( mem_we_o                              )
  );

  mem_resp_join #(
    .NumBanks ( NumBanks ),
    .BufDepth ( BufDepth )
  ) i_mem_resp_join (
    .clk_i        ( clk_i              ),
    .arst_n_i     ( arst_n_i           ),
    .meta_push_i  ( meta_push          ),
    .meta_i       ( meta_join          ),
    .credit_ok_o  ( credit_ok          ),
    .mem_rvalid_i ( mem_rvalid_i       ),
    .mem_rdata_i  ( mem_rdata_i        ),
    .r_valid_o    ( axi_resp_o.r_valid ),
    .r_o          ( axi_resp_o.r       ),
    .r_ready_i    ( axi_req_i.r_ready  ),
    .b_valid_o    ( axi_resp_o.b_valid ),
    .b_o          ( axi_resp_o.b       ),
    .b_ready_i    ( axi_req_i.b_ready  ),
    .idle_o       ( join_idle          )
  );

  // Only incrementing bursts can be stepped by a fixed beat size.
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    aw_fire |-> axi_req_i.aw.burst == BURST_INCR);
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ar_fire |-> axi_req_i.ar.burst == BURST_INCR);
  // The master's W last must agree with the length taken from AW.
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    w_fire |-> axi_req_i.w.last == wr_last);

endmodule

`default_nettype wire

// ==== mem_bank_split.sv ====
// The beat inputs must stay stable from beat_valid_i until beat_ready_o. NumBanks divides DATA_W.
`timescale 1ns/1ps
`default_nettype none

module mem_bank_split #(
  parameter int unsigned AddrWidth = 10,
  parameter int unsigned NumBanks  = 2
) (
  input  logic                                                    clk_i,
  input  logic                                                    arst_n_i,
  input  logic                                                    beat_valid_i,
  output logic                                                    beat_ready_o,
  input  logic [AddrWidth-1:0]                                    beat_addr_i,
  input  logic [axi_mem_pkg::DATA_W-1:0]                          beat_wdata_i,
  input  logic [axi_mem_pkg::STRB_W-1:0]                          beat_strb_i,
  input  axi_mem_pkg::beat_meta_t                                 beat_meta_i,
  output logic                                                    meta_push_o,
  output axi_mem_pkg::beat_meta_t                                 meta_o,
  output logic [NumBanks-1:0]                                     mem_req_o,
  input  logic [NumBanks-1:0]                                     mem_gnt_i,
  output logic [NumBanks-1:0][AddrWidth-1:0]                      mem_addr_o,
  output logic [NumBanks-1:0][axi_mem_pkg::DATA_W/NumBanks-1:0]   mem_wdata_o,
  output logic [NumBanks-1:0][axi_mem_pkg::DATA_W/NumBanks/8-1:0] mem_strb_o,
  output logic [NumBanks-1:0]                                     mem_we_o
);
  import axi_mem_pkg::*;

  localparam int unsigned BankW = DATA_W / NumBanks;
  localparam int unsigned BankS = BankW / 8;

  // Banks that already took their part of the current beat.
  logic [NumBanks-1:0] done_q;
  // Banks that are finished once this cycle is over.
  logic [NumBanks-1:0] settled;

  assign settled      = done_q | mem_gnt_i;
  assign beat_ready_o = beat_valid_i && (&settled);

  // The joiner learns about a beat only once every bank has taken it.
  assign meta_push_o = beat_ready_o;
  assign meta_o      = beat_meta_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_q <= '0;
    end else if (beat_ready_o) begin
      done_q <= '0;
    end else if (beat_valid_i) begin
      done_q <= done_q | (mem_req_o & mem_gnt_i);
    end
  end

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    // A granted bank drops out while slower banks keep waiting.
    assign mem_req_o[b]   = beat_valid_i && !done_q[b];
    assign mem_addr_o[b]  = beat_addr_i;
    assign mem_wdata_o[b] = beat_wdata_i[b*BankW +: BankW];
    assign mem_strb_o[b]  = beat_strb_i[b*BankS +: BankS];
    assign mem_we_o[b]    = beat_meta_i.we;

    // A waiting request holds until its bank grants.
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      mem_req_o[b] && !mem_gnt_i[b] |=> mem_req_o[b] && $stable(mem_addr_o[b]));
  end

endmodule

`default_nettype wire

// ==== mem_resp_join.sv ====
// Expects exactly one answer per bank per issued beat. Banks answer in issue order.
`timescale 1ns/1ps
`default_nettype none

module mem_resp_join #(
  parameter int unsigned NumBanks = 2,
  parameter int unsigned BufDepth = 2
) (
  input  logic                                                  clk_i,
  input  logic                                                  arst_n_i,
  input  logic                                                  meta_push_i,
  input  axi_mem_pkg::beat_meta_t                               meta_i,
  output logic                                                  credit_ok_o,
  input  logic [NumBanks-1:0]                                   mem_rvalid_i,
  input  logic [NumBanks-1:0][axi_mem_pkg::DATA_W/NumBanks-1:0] mem_rdata_i,
  output logic                                                  r_valid_o,
  output axi_mem_pkg::axi_r_t                                   r_o,
  input  logic                                                  r_ready_i,
  output logic                                                  b_valid_o,
  output axi_mem_pkg::axi_b_t                                   b_o,
  input  logic                                                  b_ready_i,
  output logic                                                  idle_o
);
  import axi_mem_pkg::*;

  localparam int unsigned BankW = DATA_W / NumBanks;
  localparam int unsigned PtrW  = (BufDepth > 1) ? $clog2(BufDepth) : 1;
  localparam int unsigned CntW  = $clog2(BufDepth + 1);

  // All FIFOs pop together, so they share one read pointer.
  function automatic logic [PtrW-1:0] ptr_next(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(BufDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  beat_meta_t                     meta_mem [BufDepth];
  logic [PtrW-1:0]                meta_wr_q;
  logic [PtrW-1:0]                rd_q;
  logic [CntW-1:0]                meta_cnt_q;
  logic [NumBanks-1:0]            bank_ne;
  logic [NumBanks-1:0][BankW-1:0] bank_head;
  beat_meta_t                     head;
  logic                           pop_ok;
  logic                           pop;

  // Entries in the meta FIFO are the reserved beats.
  // A beat in the splitter is only started while one more fits.
  assign credit_ok_o = meta_cnt_q < CntW'(BufDepth);
  assign idle_o      = (meta_cnt_q == '0) && !(|bank_ne);

  assign head   = meta_mem[rd_q];
  assign pop_ok = (meta_cnt_q != '0) && (&bank_ne);
  // Write beats before the last one leave without any bus response.
  assign pop    = pop_ok && (head.we ? (!head.last || b_ready_i) : r_ready_i);

  assign r_valid_o = pop_ok && !head.we;
  assign r_o       = '{id: head.id, data: bank_head, resp: RESP_OKAY, last: head.last};
  assign b_valid_o = pop_ok && head.we && head.last;
  assign b_o       = '{id: head.id, resp: RESP_OKAY};

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      meta_wr_q  <= '0;
      rd_q       <= '0;
      meta_cnt_q <= '0;
    end else begin
      if (meta_push_i) begin
        meta_wr_q <= ptr_next(meta_wr_q);
      end
      if (pop) begin
        rd_q <= ptr_next(rd_q);
      end
      meta_cnt_q <= meta_cnt_q + CntW'(meta_push_i) - CntW'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (meta_push_i) begin
      meta_mem[meta_wr_q] <= meta_i;
    end
  end

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    meta_push_i |-> meta_cnt_q < CntW'(BufDepth));

  // One data FIFO per bank.
  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank_fifo
    logic [BankW-1:0] data_mem [BufDepth];
    logic [PtrW-1:0]  wr_q;
    logic [CntW-1:0]  cnt_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        wr_q  <= '0;
        cnt_q <= '0;
      end else begin
        if (mem_rvalid_i[b]) begin
          wr_q <= ptr_next(wr_q);
        end
        cnt_q <= cnt_q + CntW'(mem_rvalid_i[b]) - CntW'(pop);
      end
    end

    always_ff @(posedge clk_i) begin
      if (mem_rvalid_i[b]) begin
        data_mem[wr_q] <= mem_rdata_i[b];
      end
    end

    assign bank_ne[b]   = (cnt_q != '0);
    assign bank_head[b] = data_mem[rd_q];

    // The credit taken at issue must leave room for every bank answer.
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      mem_rvalid_i[b] |-> cnt_q < CntW'(BufDepth));
  end

endmodule

`default_nettype wire

// ==== sram_banks.sv ====
// Memory contents are not reset. Granting follows bank_stall_i even without a request.
`timescale 1ns/1ps
`default_nettype none

module sram_banks #(
  parameter int unsigned AddrWidth = 10,
  parameter int unsigned NumBanks  = 2
) (
  input  logic                                                    clk_i,
  input  logic                                                    arst_n_i,
  input  logic [NumBanks-1:0]                                     bank_stall_i,
  input  logic [NumBanks-1:0]                                     mem_req_i,
  output logic [NumBanks-1:0]                                     mem_gnt_o,
  input  logic [NumBanks-1:0][AddrWidth-1:0]                      mem_addr_i,
  input  logic [NumBanks-1:0][axi_mem_pkg::DATA_W/NumBanks-1:0]   mem_wdata_i,
  input  logic [NumBanks-1:0][axi_mem_pkg::DATA_W/NumBanks/8-1:0] mem_strb_i,
  input  logic [NumBanks-1:0]                                     mem_we_i,
  output logic [NumBanks-1:0]                                     mem_rvalid_o,
  output logic [NumBanks-1:0][axi_mem_pkg::DATA_W/NumBanks-1:0]   mem_rdata_o
);
  import axi_mem_pkg::*;

  localparam int unsigned BankW = DATA_W / NumBanks;
  localparam int unsigned BankS = BankW / 8;
  // One bank word per full beat of address space.
  localparam int unsigned Depth = 2 ** (AddrWidth - SIZE_FULL);

  // A stalled bank simply refuses this cycle.
  assign mem_gnt_o = ~bank_stall_i;

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    logic [BankW-1:0]             ram [Depth];
    logic [AddrWidth-SIZE_FULL-1:0] idx;
    logic                         access;

    // Every bank sees the beat address, so the word index drops the byte offset.
    assign idx    = mem_addr_i[b][AddrWidth-1:SIZE_FULL];
    assign access = mem_req_i[b] && mem_gnt_o[b];

    // Reads and writes both return the word held before this access.
    always_ff @(posedge clk_i) begin
      if (access) begin
        mem_rdata_o[b] <= ram[idx];
        if (mem_we_i[b]) begin
          for (int i = 0; i < BankS; i++) begin
            if (mem_strb_i[b][i]) begin
              ram[idx][i*8 +: 8] <= mem_wdata_i[b][i*8 +: 8];
            end
          end
        end
      end
    end

    // Every granted request gets its answer one cycle later.
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        mem_rvalid_o[b] <= 1'b0;
      end else begin
        mem_rvalid_o[b] <= access;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_axi_mem_subsys.sv ====
// Runs from the project root so axi_mem_cases.txt is found. Assumes AddrWidth 10 (1 KiB), two banks.
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem_subsys;
  import axi_mem_pkg::*;

  localparam int unsigned MemBytes = 1024;
  localparam int unsigned MaxCases = 32;

  logic            clk;
  logic            arst_n;
  axi_req_t        axi_req;
  axi_resp_t       axi_resp;
  logic [1:0]      bank_stall;
  logic            busy;

  // Case table as read from the case file.
  logic [7:0]      c_op   [MaxCases];
  logic [ID_W-1:0] c_id   [MaxCases];
  logic [31:0]     c_addr [MaxCases];
  int              c_len  [MaxCases];
  logic [63:0]     c_base [MaxCases];
  logic [7:0]      c_strb [MaxCases];
  int              num_cases   = 0;
  int              total_beats = 0;
  int              cycles      = 0;
  int              cycle_limit = 0;
  logic [31:0]     lfsr        = 32'hf2f4;
  // Byte-wide model of the whole memory, updated on every accepted W beat.
  logic [7:0]      ref_mem [MemBytes];

  axi_mem_subsys #(
    .AddrWidth ( 10 ),
    .NumBanks  ( 2  ),
    .BufDepth  ( 2  )
  ) i_dut (
    .clk_i        ( clk        ),
    .arst_n_i     ( arst_n     ),
    .axi_req_i    ( axi_req    ),
    .axi_resp_o   ( axi_resp   ),
    .bank_stall_i ( bank_stall ),
    .busy_o       ( busy       )
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_random_bit(output logic b);
    b    = lfsr[0];
    lfsr = lfsr_next(lfsr);
  endtask

  // New bank stalls and R/B ready levels for this cycle.
  task automatic randomize_levels();
    logic b;
    for (int k = 0; k < 2; k++) begin
      take_random_bit(b);
      bank_stall[k] = b;
    end
    take_random_bit(b);
    axi_req.r_ready = b;
    take_random_bit(b);
    axi_req.b_ready = b;
  endtask

  // Byte i of beat n of a burst: aligned start, 8 bytes per beat, wrap at 1 KiB.
  function automatic int byte_addr(input logic [31:0] addr, input int n, input int i);
    return ((addr & 32'hffff_fff8) + 8 * n + i) % MemBytes;
  endfunction

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      stop_with_error($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      stop_with_error("Timeout: the DUT did not finish the cases within the cycle limit.");
    end
  end

  // Runs a write case, a read case, or both at once. An index below zero means none.
  task automatic run_pair(input int wi, input int ri);
    int          w_beat;
    int          r_beat;
    int          w_last;
    int          r_last;
    logic        aw_pend;
    logic        ar_pend;
    logic        b_seen;
    logic [63:0] exp_data;
    string       w_name;
    string       r_name;
    w_beat  = 0;
    r_beat  = 0;
    w_last  = (wi >= 0) ? c_len[wi] : -1;
    r_last  = (ri >= 0) ? c_len[ri] : -1;
    aw_pend = (wi >= 0);
    ar_pend = (ri >= 0);
    b_seen  = (wi < 0);
    w_name  = (wi >= 0) ? $sformatf("case %0d write id %h", wi + 1, c_id[wi]) : "";
    r_name  = (ri >= 0) ? $sformatf("case %0d read id %h", ri + 1, c_id[ri]) : "";
    while (aw_pend || ar_pend || w_beat <= w_last || r_beat <= r_last || !b_seen) begin
      @(posedge clk);
      #2;
      randomize_levels();
      axi_req.aw_valid = aw_pend;
      axi_req.ar_valid = ar_pend;
      axi_req.w_valid  = (w_beat <= w_last);
      if (wi >= 0) begin
        axi_req.aw     = '{id: c_id[wi], addr: c_addr[wi], len: 8'(c_len[wi]), burst: BURST_INCR};
        axi_req.w.data = c_base[wi] + 64'(w_beat);
        axi_req.w.strb = c_strb[wi];
        axi_req.w.last = (w_beat == w_last);
      end
      if (ri >= 0) begin
        axi_req.ar = '{id: c_id[ri], addr: c_addr[ri], len: 8'(c_len[ri]), burst: BURST_INCR};
      end
      // Mid-cycle, every handshake that the next edge completes is visible.
      @(negedge clk);
      if (axi_req.aw_valid && axi_resp.aw_ready) begin
        aw_pend = 1'b0;
      end
      if (axi_req.ar_valid && axi_resp.ar_ready) begin
        ar_pend = 1'b0;
      end
      if (axi_req.w_valid && axi_resp.w_ready) begin
        for (int i = 0; i < 8; i++) begin
          if (c_strb[wi][i]) begin
            ref_mem[byte_addr(c_addr[wi], w_beat, i)] = axi_req.w.data[i*8 +: 8];
          end
        end
        w_beat++;
      end
      if (axi_resp.r_valid && axi_req.r_ready) begin
        if (r_beat > r_last) begin
          stop_with_error("An R beat arrived while no read burst was open.");
        end
        for (int i = 0; i < 8; i++) begin
          exp_data[i*8 +: 8] = ref_mem[byte_addr(c_addr[ri], r_beat, i)];
        end
        check($sformatf("%s beat %0d data", r_name, r_beat), exp_data, axi_resp.r.data);
        check($sformatf("%s beat %0d id", r_name, r_beat), 64'(c_id[ri]), 64'(axi_resp.r.id));
        check($sformatf("%s beat %0d resp", r_name, r_beat), 64'd0, 64'(axi_resp.r.resp));
        check($sformatf("%s beat %0d last", r_name, r_beat), 64'(r_beat == r_last),
              64'(axi_resp.r.last));
        r_beat++;
      end
      if (axi_resp.b_valid && axi_req.b_ready) begin
        if (b_seen || w_beat <= w_last) begin
          stop_with_error("A B response arrived before all W beats of its burst were sent.");
        end
        check($sformatf("%s b id", w_name), 64'(c_id[wi]), 64'(axi_resp.b.id));
        check($sformatf("%s b resp", w_name), 64'd0, 64'(axi_resp.b.resp));
        b_seen = 1'b1;
      end
    end
    // The final response leaves at this edge, after which all valids drop.
    @(posedge clk);
    #2;
    randomize_levels();
    axi_req.aw_valid = 1'b0;
    axi_req.ar_valid = 1'b0;
    axi_req.w_valid  = 1'b0;
    @(negedge clk);
    check($sformatf("case %0d busy at end", (wi > ri ? wi : ri) + 1), 64'd0, 64'(busy));
    check($sformatf("case %0d r_valid at end", (wi > ri ? wi : ri) + 1), 64'd0,
          64'(axi_resp.r_valid));
    check($sformatf("case %0d b_valid at end", (wi > ri ? wi : ri) + 1), 64'd0,
          64'(axi_resp.b_valid));
  endtask

  initial begin
    int    fd;
    int    n;
    int    i;
    string line;
    axi_req    = '0;
    bank_stall = '0;
    arst_n     = 1'b0;
    fd = $fopen("axi_mem_cases.txt", "r");
    if (fd == 0) begin
      stop_with_error("Cannot open the case file axi_mem_cases.txt.");
    end
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) == 0) begin
        break;
      end
      // Blank lines and lines starting with a hash are skipped.
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%c %h %h %d %h %h", c_op[num_cases], c_id[num_cases],
                  c_addr[num_cases], c_len[num_cases], c_base[num_cases], c_strb[num_cases]);
      if (n != 6 || num_cases >= MaxCases) begin
        stop_with_error($sformatf("Case file line cannot be read: %s", line));
      end
      total_beats += c_len[num_cases] + 1;
      num_cases++;
    end
    $fclose(fd);
    cycle_limit = total_beats * 40 + 200;

    repeat (4) @(posedge clk);
    #2;
    arst_n = 1'b1;
    // Nothing may be pending before the first request.
    @(negedge clk);
    check("reset busy", 64'd0, 64'(busy));
    check("reset b_valid", 64'd0, 64'(axi_resp.b_valid));
    check("reset r_valid", 64'd0, 64'(axi_resp.r_valid));

    i = 0;
    while (i < num_cases) begin
      if (c_op[i] == "W") begin
        run_pair(i, -1);
        i++;
      end else if (c_op[i] == "R") begin
        run_pair(-1, i);
        i++;
      end else if (c_op[i] == "P" && i + 1 < num_cases && c_op[i+1] == "R") begin
        // Write and read run side by side on disjoint ranges.
        run_pair(i, i + 1);
        i += 2;
      end else begin
        stop_with_error($sformatf("Case %0d has an unknown operation.", i + 1));
      end
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire
